//--- rtl/fe_ctl_pkg.sv
/*
  front end control shared definitions
  widths of the SPI frame and host registers, conditioning modes
  and the host register map
*/

package fe_ctl_pkg;

  //////////////////////////////
  // widths

  // conditioning vector, top bit down
  // monitor[7:0], led, pc_sw, himux[3:0], azmux[3:0]
  localparam int cond_w = 18;

  // host register payload, low bits of a frame
  localparam int reg_w = 24;

  // one frame is write flag, address, data
  localparam int frame_w = 32;

  // register address between write flag and data
  localparam int addr_w = 7;

  //////////////////////////////
  // conditioning source select

  typedef enum logic [1:0] {
    // everything blanked
    mode_off    = 2'd0,
    // binary count, one step per clk
    mode_count  = 2'd1,
    // single one rotating left
    mode_walk   = 2'd2,
    // value written by the host
    mode_direct = 2'd3
  } cond_mode_e;

  //////////////////////////////
  // host register map

  typedef enum logic [addr_w-1:0] {
    // scratch, full 24 bits
    addr_led     = 7'h07,
    // bit0 routes cs2 to the 4094 chain, bit1 chain output enable
    addr_spi_mux = 7'h08,
    // bits 1:0 conditioning mode
    addr_mode    = 7'h09,
    // bits 17:0 direct conditioning value
    addr_direct  = 7'h0a
  } reg_addr_e;

endpackage

//--- rtl/spi_reg_bank.sv
/*
  host register bank behind an SPI slave
  SPI mode 0 oversampled in clk, 32-bit frames of write flag,
  address and data; read data goes back MSB first
*/

`timescale 1ns/1ps

module spi_reg_bank (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            sck,
  input  logic                            cs,
  input  logic                            cs2,
  input  logic                            mosi,
  output logic                            dout,
  output logic [1:0]                      spi_mux,
  output fe_ctl_pkg::cond_mode_e          mode,
  output logic [fe_ctl_pkg::cond_w-1:0]   direct,
  output logic                            chain_oe
);

  localparam int frame_w = fe_ctl_pkg::frame_w;
  localparam int reg_w   = fe_ctl_pkg::reg_w;
  localparam int addr_w  = fe_ctl_pkg::addr_w;
  // write flag plus address
  localparam int hdr_bits = addr_w + 1;
  // one extra count so a long frame stands out
  localparam int cnt_w = $clog2(frame_w) + 1;

  logic sck_meta, sck_s, sck_d;
  logic cs_meta, cs_s, cs_d;
  logic mosi_meta, mosi_s;
  logic sck_rise, sck_fall, cs_rise;
  logic commit;
  logic [cnt_w-1:0] bit_cnt;
  logic [frame_w-1:0] rx_sr;
  logic [reg_w-1:0] rd_sr;
  logic [reg_w-1:0] rd_val;
  logic [reg_w-1:0] led_r;

  //////////////////////////////
  // input synchronizers

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      // sck idles low, cs idles high
      sck_meta  <= 1'b0;
      sck_s     <= 1'b0;
      sck_d     <= 1'b0;
      cs_meta   <= 1'b1;
      cs_s      <= 1'b1;
      cs_d      <= 1'b1;
      mosi_meta <= 1'b0;
      mosi_s    <= 1'b0;
    end
    else
    begin
      sck_meta  <= sck;
      sck_s     <= sck_meta;
      sck_d     <= sck_s;
      cs_meta   <= cs;
      cs_s      <= cs_meta;
      cs_d      <= cs_s;
      mosi_meta <= mosi;
      mosi_s    <= mosi_meta;
    end
  end

  // edges only count inside a frame
  assign sck_rise = sck_s & ~sck_d & ~cs_s;
  assign sck_fall = ~sck_s & sck_d & ~cs_s;
  assign cs_rise  = cs_s & ~cs_d;

  // only a write frame of exactly 32 bits is committed
  assign commit = cs_rise && (bit_cnt == cnt_w'(frame_w)) && rx_sr[frame_w-1];

  //////////////////////////////
  // frame receive

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      bit_cnt <= '0;
    else if (cs_s)
      bit_cnt <= '0;
    else if (sck_rise && (bit_cnt <= cnt_w'(frame_w)))
      // saturates one past a full frame
      bit_cnt <= bit_cnt + 1'b1;
  end

  // mosi is taken on each sck rise, MSB first
  always_ff @(posedge clk)
  begin
    if (sck_rise)
      rx_sr <= {rx_sr[frame_w-2:0], mosi_s};
  end

  //////////////////////////////
  // read path

  // address sits in the low bits once the header is in
  always_comb
  begin
    case (rx_sr[addr_w-1:0])
      fe_ctl_pkg::addr_led:     rd_val = led_r;
      fe_ctl_pkg::addr_spi_mux: rd_val = reg_w'(spi_mux);
      fe_ctl_pkg::addr_mode:    rd_val = reg_w'(mode);
      fe_ctl_pkg::addr_direct:  rd_val = reg_w'(direct);
      // unknown address reads zero
      default:                  rd_val = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      rd_sr <= '0;
    else if (sck_fall && (bit_cnt == cnt_w'(hdr_bits)))
      // first fall after the header puts data bit 23 out
      rd_sr <= rd_val;
    else if (sck_fall && (bit_cnt > cnt_w'(hdr_bits)))
      rd_sr <= {rd_sr[reg_w-2:0], 1'b0};
  end

  assign dout = rd_sr[reg_w-1];

  //////////////////////////////
  // host registers

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      led_r   <= '0;
      spi_mux <= '0;
      mode    <= fe_ctl_pkg::mode_off;
      direct  <= '0;
    end
    else if (commit)
    begin
      // address is bits 30..24, data bits 23..0
      case (rx_sr[frame_w-2 -: addr_w])
        fe_ctl_pkg::addr_led:     led_r <= rx_sr[reg_w-1:0];
        fe_ctl_pkg::addr_spi_mux: spi_mux <= rx_sr[1:0];
        fe_ctl_pkg::addr_mode:    mode <= fe_ctl_pkg::cond_mode_e'(rx_sr[1:0]);
        fe_ctl_pkg::addr_direct:  direct <= rx_sr[fe_ctl_pkg::cond_w-1:0];
        default:                  ;
      endcase
    end
  end

  assign chain_oe = spi_mux[1];

  // host must never select the bank and the 4094 chain at once
  a_cs_exclusive : assert property (@(posedge clk) disable iff (!arst_n)
    !(!cs && !cs2));

endmodule

//--- rtl/spi_route.sv
/*
  SPI pass-through to the 4094 chain
  gates sck and mosi onto the chain while cs2 is low, selects miso
  and strobes the chain after a routed transfer
*/

`timescale 1ns/1ps

module spi_route (
  input  logic clk,
  input  logic arst_n,
  input  logic sck,
  input  logic mosi,
  input  logic cs,
  input  logic cs2,
  input  logic route_en,
  input  logic bank_dout,
  input  logic chain_miso,
  output logic miso,
  output logic chain_sck,
  output logic chain_mosi,
  output logic chain_strobe
);

  logic routed;
  logic cs2_meta, cs2_s, cs2_d;
  logic routed_seen;
  logic cs2_rise;

  //////////////////////////////
  // combinational routing

  // chain only sees the host while cs2 is low and routing is on
  assign routed     = ~cs2 & route_en;
  assign chain_sck  = routed & sck;
  assign chain_mosi = routed & mosi;

  always_comb
  begin
    if (!cs)
      miso = bank_dout;
    else if (routed)
      miso = chain_miso;
    else
      miso = 1'b0;
  end

  //////////////////////////////
  // strobe

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      cs2_meta <= 1'b1;
      cs2_s    <= 1'b1;
      cs2_d    <= 1'b1;
    end
    else
    begin
      cs2_meta <= cs2;
      cs2_s    <= cs2_meta;
      cs2_d    <= cs2_s;
    end
  end

  assign cs2_rise = cs2_s & ~cs2_d;

  // remember that this transfer went through to the chain
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      routed_seen <= 1'b0;
    else if (cs2_rise)
      routed_seen <= 1'b0;
    else if (!cs2_s && route_en)
      routed_seen <= 1'b1;
  end

  // 4094 latches its shift stages on this pulse
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      chain_strobe <= 1'b0;
    else
      chain_strobe <= cs2_rise & routed_seen;
  end

  a_strobe_single : assert property (@(posedge clk) disable iff (!arst_n)
    chain_strobe |=> !chain_strobe);

endmodule

//--- rtl/pattern_gen.sv
/*
  conditioning test patterns
  a binary count and a walking one, both stepping every clk
*/

`timescale 1ns/1ps

module pattern_gen (
  input  logic                          clk,
  input  logic                          arst_n,
  output logic [fe_ctl_pkg::cond_w-1:0] count,
  output logic [fe_ctl_pkg::cond_w-1:0] walk
);

  localparam int cond_w = fe_ctl_pkg::cond_w;

  //////////////////////////////
  // counting pattern

  // exercises every output pin at a different rate
  // bit0 toggles each clk, msb is the slowest
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      count <= '0;
    else
      // wraps at cond_w bits
      count <= count + 1'b1;
  end

  //////////////////////////////
  // walking one

  // one pin high at a time, useful for
  // spotting shorts between neighbouring lines
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      // starts on azmux bit 0
      walk <= cond_w'(1);
    else
      // rotate left, msb comes back to bit 0
      walk <= {walk[cond_w-2:0], walk[cond_w-1]};
  end

endmodule

//--- rtl/mode_select.sv
/*
  conditioning source select
  registers the source picked by mode and blanks the outputs for
  blank_cycles clks on a mode change, so switches break before make
*/

`timescale 1ns/1ps

module mode_select #(
  parameter int blank_cycles = 2
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  fe_ctl_pkg::cond_mode_e        mode,
  input  logic [fe_ctl_pkg::cond_w-1:0] count,
  input  logic [fe_ctl_pkg::cond_w-1:0] walk,
  input  logic [fe_ctl_pkg::cond_w-1:0] direct,
  output logic [fe_ctl_pkg::cond_w-1:0] cond
);

  // holds blank_cycles - 1, at least one bit
  localparam int cnt_w = (blank_cycles > 1) ? $clog2(blank_cycles) : 1;

  fe_ctl_pkg::cond_mode_e mode_q;
  logic [cnt_w-1:0] blank_cnt;
  logic mode_change;
  logic [fe_ctl_pkg::cond_w-1:0] src;

  //////////////////////////////
  // source mux

  always_comb
  begin
    case (mode)
      fe_ctl_pkg::mode_count:  src = count;
      fe_ctl_pkg::mode_walk:   src = walk;
      fe_ctl_pkg::mode_direct: src = direct;
      // mode off drives everything low
      default:                 src = '0;
    endcase
  end

  // direct value changes alone are not a mode change
  assign mode_change = (mode != mode_q);

  //////////////////////////////
  // blanking

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      mode_q    <= fe_ctl_pkg::mode_off;
      blank_cnt <= '0;
      cond      <= '0;
    end
    else if (mode_change)
    begin
      // first blank cycle starts here
      mode_q    <= mode;
      blank_cnt <= cnt_w'(blank_cycles - 1);
      cond      <= '0;
    end
    else if (blank_cnt != '0)
    begin
      blank_cnt <= blank_cnt - 1'b1;
      cond      <= '0;
    end
    else
      // steady state, source one clk late
      cond <= src;
  end

  // outputs stay low for the whole blanking run after a mode change
  a_blank_zero : assert property (@(posedge clk) disable iff (!arst_n)
    mode_change |=> (cond == '0) [*blank_cycles]);

endmodule

//--- rtl/fe_ctl_top.sv
/*
  analog front end control top level
  host SPI register bank, 4094 chain routing, test patterns and
  the conditioning output select
*/

`timescale 1ns/1ps

module fe_ctl_top #(
  parameter int blank_cycles = 2
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       spi_sck,
  input  logic       spi_cs,
  input  logic       spi_cs2,
  input  logic       spi_mosi,
  input  logic       chain_miso,
  output logic       spi_miso,
  output logic       chain_sck,
  output logic       chain_mosi,
  output logic       chain_strobe,
  output logic       chain_oe,
  output logic [7:0] monitor,
  output logic       led,
  output logic       sig_pc_sw,
  output logic [3:0] himux_ctl,
  output logic [3:0] azmux_ctl
);

  logic bank_dout;
  logic [1:0] spi_mux;
  fe_ctl_pkg::cond_mode_e mode;
  logic [fe_ctl_pkg::cond_w-1:0] direct;
  logic [fe_ctl_pkg::cond_w-1:0] count;
  logic [fe_ctl_pkg::cond_w-1:0] walk;
  logic [fe_ctl_pkg::cond_w-1:0] cond;

  //////////////////////////////
  // host registers

  // bit1 of spi_mux leaves as chain_oe
  spi_reg_bank spi_reg_bank_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .sck      (spi_sck),
    .cs       (spi_cs),
    .cs2      (spi_cs2),
    .mosi     (spi_mosi),
    .dout     (bank_dout),
    .spi_mux  (spi_mux),
    .mode     (mode),
    .direct   (direct),
    .chain_oe (chain_oe)
  );

  //////////////////////////////
  // 4094 chain and miso

  spi_route spi_route_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .sck          (spi_sck),
    .mosi         (spi_mosi),
    .cs           (spi_cs),
    .cs2          (spi_cs2),
    .route_en     (spi_mux[0]),
    .bank_dout    (bank_dout),
    .chain_miso   (chain_miso),
    .miso         (spi_miso),
    .chain_sck    (chain_sck),
    .chain_mosi   (chain_mosi),
    .chain_strobe (chain_strobe)
  );

  //////////////////////////////
  // conditioning

  pattern_gen pattern_gen_i (
    .clk    (clk),
    .arst_n (arst_n),
    .count  (count),
    .walk   (walk)
  );

  mode_select #(
    .blank_cycles (blank_cycles)
  ) mode_select_i (
    .clk    (clk),
    .arst_n (arst_n),
    .mode   (mode),
    .count  (count),
    .walk   (walk),
    .direct (direct),
    .cond   (cond)
  );

  // pin order follows the package, top bit down
  assign {monitor, led, sig_pc_sw, himux_ctl, azmux_ctl} = cond;

endmodule

//--- testbench/fe_ctl_checker.sv
/*
  front end control checker
  watches the DUT pins, compares them with the expectations that
  the testbench drives and counts errors
*/

`timescale 1ns/1ps

module fe_ctl_checker #(
  parameter int blank_cycles = 2
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic [fe_ctl_pkg::cond_w-1:0] cond,
  input  logic                          spi_sck,
  input  logic                          spi_cs,
  input  logic                          spi_cs2,
  input  logic                          spi_mosi,
  input  logic                          spi_miso,
  input  logic                          chain_miso,
  input  logic                          chain_sck,
  input  logic                          chain_mosi,
  input  logic                          chain_strobe,
  input  logic                          chain_oe,
  input  logic                          eq_en,
  input  logic [fe_ctl_pkg::cond_w-1:0] exp_cond,
  input  logic                          count_en,
  input  logic                          walk_en,
  input  logic                          blank_en,
  input  logic                          nozero_en,
  input  logic                          route_exp,
  input  logic                          exp_oe,
  input  logic [fe_ctl_pkg::reg_w-1:0]  exp_rd,
  output int                            errors,
  output int                            runs_seen
);

  localparam int cw = fe_ctl_pkg::cond_w;

  logic sck_q, cs_q, cs2_q;
  logic routed_now;
  logic have_prev;
  logic [2:0] rise_hist;
  logic [31:0] mosi_sr;
  logic [23:0] miso_sr;
  logic [cw-1:0] prev;
  int nbits, zrun, idle;

  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    errors++;
    $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
  endtask

  task automatic note_error(input string what);
    errors++;
    $display("%s at %0t", what, $time);
  endtask

  always @(posedge clk)
  begin
    if (!arst_n)
    begin
      sck_q     = 1'b0;
      cs_q      = 1'b1;
      cs2_q     = 1'b1;
      rise_hist = '0;
      have_prev = 1'b0;
      nbits     = 0;
      zrun      = 0;
      idle      = 0;
      runs_seen = 0;
    end
    else
    begin
      //////////////////////////////
      // host frames, read data only
      if (!spi_cs && spi_sck && !sck_q)
      begin
        mosi_sr = {mosi_sr[30:0], spi_mosi};
        miso_sr = {miso_sr[22:0], spi_miso};
        nbits++;
      end
      // full read frame just ended
      if (spi_cs && !cs_q)
      begin
        if (nbits == 32 && !mosi_sr[31] && miso_sr !== exp_rd)
          mismatch("spi_miso", miso_sr, exp_rd);
        nbits = 0;
      end
      // chain_oe settles a few clks after the frame
      idle = (spi_cs && spi_cs2) ? idle + 1 : 0;
      if (idle > 4 && chain_oe !== exp_oe)
        mismatch("chain_oe", chain_oe, exp_oe);

      //////////////////////////////
      // 4094 routing and strobe
      routed_now = route_exp & ~spi_cs2;
      if (chain_sck !== (routed_now & spi_sck))
        mismatch("chain_sck", chain_sck, routed_now & spi_sck);
      if (chain_mosi !== (routed_now & spi_mosi))
        mismatch("chain_mosi", chain_mosi, routed_now & spi_mosi);
      if (spi_cs && spi_miso !== (routed_now & chain_miso))
        mismatch("spi_miso", spi_miso, routed_now & chain_miso);
      // strobe due three clks after the sampled cs2 rise
      if (chain_strobe !== (rise_hist[2] & route_exp))
        mismatch("chain_strobe", chain_strobe, rise_hist[2] & route_exp);
      rise_hist = {rise_hist[1:0], spi_cs2 & ~cs2_q};

      //////////////////////////////
      // conditioning outputs
      if (eq_en && cond !== exp_cond)
        mismatch("cond", cond, exp_cond);
      if (nozero_en && cond == '0)
        note_error("conditioning outputs blanked on a direct value change");
      if (count_en && have_prev && cond !== cw'(prev + 1'b1))
        mismatch("cond", cond, cw'(prev + 1'b1));
      if (walk_en && !$onehot(cond))
        note_error("walking pattern is not one-hot");
      if (walk_en && have_prev && cond !== {prev[cw-2:0], prev[cw-1]})
        mismatch("cond", cond, {prev[cw-2:0], prev[cw-1]});
      have_prev = count_en | walk_en;
      prev = cond;

      // length of the zero gap between old and new source
      if (!blank_en)
        zrun = 0;
      else if (cond == '0)
        zrun++;
      else if (zrun != 0)
      begin
        if (zrun != blank_cycles)
          mismatch("blank_run", zrun, blank_cycles);
        runs_seen++;
        zrun = 0;
      end

      sck_q = spi_sck;
      cs_q  = spi_cs;
      cs2_q = spi_cs2;
    end
  end

endmodule

//--- testbench/tb_fe_ctl.sv
/*
  front end control testbench
  SPI host with register and 4094 chain transfers, a bank model
  and the stimulus for every conditioning mode
*/

`timescale 1ns/1ps

module tb_fe_ctl;

  localparam int blank_cycles = 2;
  // clks per wait before giving up
  localparam int wait_limit = 2000;

  logic clk, arst_n;
  logic spi_sck, spi_cs, spi_cs2, spi_mosi, chain_miso;
  logic spi_miso, chain_sck, chain_mosi, chain_strobe, chain_oe;
  logic [7:0] monitor;
  logic led, sig_pc_sw;
  logic [3:0] himux_ctl, azmux_ctl;
  logic [17:0] cond;
  logic eq_en, count_en, walk_en, blank_en, nozero_en, route_exp;
  logic [17:0] exp_cond;
  logic [23:0] exp_rd;
  int errors, runs_seen, timeouts;
  logic [31:0] rng;
  // register bank model
  logic [23:0] m_led;
  logic [1:0] m_mux, m_mode;
  logic [17:0] m_direct;

  always #2 clk = ~clk;

  fe_ctl_top #(
    .blank_cycles (blank_cycles)
  ) fe_ctl_top_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .spi_sck      (spi_sck),
    .spi_cs       (spi_cs),
    .spi_cs2      (spi_cs2),
    .spi_mosi     (spi_mosi),
    .chain_miso   (chain_miso),
    .spi_miso     (spi_miso),
    .chain_sck    (chain_sck),
    .chain_mosi   (chain_mosi),
    .chain_strobe (chain_strobe),
    .chain_oe     (chain_oe),
    .monitor      (monitor),
    .led          (led),
    .sig_pc_sw    (sig_pc_sw),
    .himux_ctl    (himux_ctl),
    .azmux_ctl    (azmux_ctl)
  );

  // pins back into one vector, monitor on top
  assign cond = {monitor, led, sig_pc_sw, himux_ctl, azmux_ctl};

  fe_ctl_checker #(
    .blank_cycles (blank_cycles)
  ) fe_ctl_checker_i (
    .clk (clk), .arst_n (arst_n), .cond (cond),
    .spi_sck (spi_sck), .spi_cs (spi_cs), .spi_cs2 (spi_cs2),
    .spi_mosi (spi_mosi), .spi_miso (spi_miso), .chain_miso (chain_miso),
    .chain_sck (chain_sck), .chain_mosi (chain_mosi),
    .chain_strobe (chain_strobe), .chain_oe (chain_oe),
    .eq_en (eq_en), .exp_cond (exp_cond), .count_en (count_en),
    .walk_en (walk_en), .blank_en (blank_en), .nozero_en (nozero_en),
    .route_exp (route_exp), .exp_oe (m_mux[1]), .exp_rd (exp_rd),
    .errors (errors), .runs_seen (runs_seen)
  );

  //////////////////////////////
  // model and helpers

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // read value of a host register, unknown addresses give zero
  function automatic logic [23:0] bank_read_value(input logic [6:0] addr);
    case (addr)
      fe_ctl_pkg::addr_led:     return m_led;
      fe_ctl_pkg::addr_spi_mux: return {22'd0, m_mux};
      fe_ctl_pkg::addr_mode:    return {22'd0, m_mode};
      fe_ctl_pkg::addr_direct:  return {6'd0, m_direct};
      default:                  return 24'd0;
    endcase
  endfunction

  // direct mode drives the pins straight from the register
  function automatic logic [17:0] direct_cond_value();
    return m_direct;
  endfunction

  task automatic model_write(input logic [6:0] addr, input logic [23:0] data);
    case (addr)
      fe_ctl_pkg::addr_led:     m_led = data;
      fe_ctl_pkg::addr_spi_mux: m_mux = data[1:0];
      fe_ctl_pkg::addr_mode:    m_mode = data[1:0];
      fe_ctl_pkg::addr_direct:  m_direct = data[17:0];
      default:                  ;
    endcase
  endtask

  task automatic finish_run();
    $display("checks finished with %0d errors and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  endtask

  task automatic timed_out(input string what);
    timeouts++;
    $display("timeout waiting for %s", what);
  endtask

  // inputs change 1 ns after the rising edge
  task automatic step(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // one bit per 8 clks, mosi set while sck is low
  task automatic spi_frame(input logic [31:0] frame, input int nbits);
    spi_cs = 1'b0;
    step(4);
    for (int i = 0; i < nbits; i++)
    begin
      spi_mosi = frame[31-i];
      step(4);
      spi_sck = 1'b1;
      step(4);
      spi_sck = 1'b0;
    end
    step(4);
    spi_cs   = 1'b1;
    spi_mosi = 1'b0;
    step(6);
  endtask

  task automatic reg_write(input logic [6:0] addr, input logic [23:0] data);
    model_write(addr, data);
    spi_frame({1'b1, addr, data}, 32);
  endtask

  task automatic reg_read(input logic [6:0] addr);
    exp_rd = bank_read_value(addr);
    spi_frame({1'b0, addr, 24'd0}, 32);
  endtask

  task automatic write_read_random(input logic [6:0] addr);
    rng = lcg(rng);
    reg_write(addr, rng[31:8]);
    reg_read(addr);
  endtask

  // host shifts the 4094 chain, chain answers with random bits
  task automatic chain_xfer(input int nbits);
    spi_cs2 = 1'b0;
    step(4);
    for (int i = 0; i < nbits; i++)
    begin
      rng        = lcg(rng);
      spi_mosi   = rng[16];
      chain_miso = rng[20];
      step(4);
      spi_sck = 1'b1;
      step(4);
      spi_sck = 1'b0;
    end
    step(4);
    spi_cs2    = 1'b1;
    spi_mosi   = 1'b0;
    chain_miso = 1'b0;
    // strobe window
    step(8);
  endtask

  task automatic wait_cond(input logic [17:0] value);
    int n;
    n = 0;
    while (cond !== value && n < wait_limit)
    begin
      step(1);
      n++;
    end
    if (cond !== value)
      timed_out("the conditioning outputs to take the expected value");
  endtask

  task automatic blanked_change(input fe_ctl_pkg::cond_mode_e new_mode);
    int target;
    int n;
    target   = runs_seen + 1;
    n        = 0;
    blank_en = 1'b1;
    reg_write(fe_ctl_pkg::addr_mode, 24'(new_mode));
    while (runs_seen < target && n < wait_limit)
    begin
      step(1);
      n++;
    end
    if (runs_seen < target)
      timed_out("the blanking gap after a mode change");
    blank_en = 1'b0;
  endtask

  //////////////////////////////
  // stimulus

  initial
  begin
    clk        = 1'b0;
    arst_n     = 1'b0;
    spi_sck    = 1'b0;
    spi_cs     = 1'b1;
    spi_cs2    = 1'b1;
    spi_mosi   = 1'b0;
    chain_miso = 1'b0;
    eq_en      = 1'b0;
    count_en   = 1'b0;
    walk_en    = 1'b0;
    blank_en   = 1'b0;
    nozero_en  = 1'b0;
    route_exp  = 1'b0;
    exp_cond   = '0;
    exp_rd     = '0;
    m_led      = '0;
    m_mux      = '0;
    m_mode     = '0;
    m_direct   = '0;
    rng        = 32'd10;
    timeouts   = 0;
    step(4);
    arst_n = 1'b1;

    // everything quiet out of reset
    eq_en = 1'b1;
    step(12);
    eq_en = 1'b0;

    for (int r = 0; r < 4; r++)
    begin
      write_read_random(fe_ctl_pkg::addr_led);
      write_read_random(fe_ctl_pkg::addr_spi_mux);
      write_read_random(fe_ctl_pkg::addr_mode);
      write_read_random(fe_ctl_pkg::addr_direct);
    end
    write_read_random(7'h0b);
    reg_read(7'h00);
    reg_read(7'h7f);
    // 16 bits only, led must keep its value
    spi_frame({1'b1, fe_ctl_pkg::addr_led, 24'h5a5a5a}, 16);
    reg_read(fe_ctl_pkg::addr_led);

    // direct mode, nonzero values so a blank gap is visible
    rng = lcg(rng);
    reg_write(fe_ctl_pkg::addr_direct, {6'd0, rng[31:14] | 18'd1});
    reg_write(fe_ctl_pkg::addr_mode, 24'(fe_ctl_pkg::mode_direct));
    wait_cond(direct_cond_value());
    exp_cond = direct_cond_value();
    eq_en    = 1'b1;
    step(20);
    eq_en     = 1'b0;
    rng       = lcg(rng);
    nozero_en = 1'b1;
    reg_write(fe_ctl_pkg::addr_direct, {6'd0, rng[31:14] | 18'd1});
    wait_cond(direct_cond_value());
    nozero_en = 1'b0;
    exp_cond  = direct_cond_value();
    eq_en     = 1'b1;
    step(20);
    eq_en = 1'b0;

    blanked_change(fe_ctl_pkg::mode_count);
    count_en = 1'b1;
    step(40);
    count_en = 1'b0;
    blanked_change(fe_ctl_pkg::mode_walk);
    walk_en = 1'b1;
    step(40);
    walk_en = 1'b0;
    blanked_change(fe_ctl_pkg::mode_direct);
    eq_en = 1'b1;
    step(20);
    eq_en = 1'b0;
    reg_write(fe_ctl_pkg::addr_mode, 24'(fe_ctl_pkg::mode_off));
    wait_cond('0);
    exp_cond = '0;
    eq_en    = 1'b1;
    step(20);
    eq_en = 1'b0;

    // routed transfer, then one with routing off
    route_exp = 1'b1;
    reg_write(fe_ctl_pkg::addr_spi_mux, 24'h3);
    chain_xfer(16);
    reg_write(fe_ctl_pkg::addr_spi_mux, 24'h2);
    route_exp = 1'b0;
    chain_xfer(16);
    finish_run();
  end

endmodule

//--- fe_ctl.f
rtl/fe_ctl_pkg.sv
rtl/spi_reg_bank.sv
rtl/spi_route.sv
rtl/pattern_gen.sv
rtl/mode_select.sv
rtl/fe_ctl_top.sv
testbench/fe_ctl_checker.sv
testbench/tb_fe_ctl.sv
